//--- include/pe_macros.svh
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// configuration memory geometry
`define PE_CFG_DEPTH 32
`define PE_CFG_PTR_W 5 // log2 of depth

`endif

//--- logic/pe_config_pkg.sv
package pe_config_pkg;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_AND    = 4'd3,
        OP_OR     = 4'd4,
        OP_XOR    = 4'd5,
        OP_SHL    = 4'd6,  // shift by b[4:0]
        OP_SHR    = 4'd7,  // logical
        OP_MUL    = 4'd8,  // low word of product
        OP_ADD2   = 4'd9,  // two 16-bit lanes
        OP_SUB2   = 4'd10,
        OP_PASS_A = 4'd11
    } pe_opcode_t;

    // register write sources
    typedef enum logic [2:0] {
        IN_N   = 3'd0,
        IN_S   = 3'd1,
        IN_W   = 3'd2,
        IN_E   = 3'd3,
        IN_LSU = 3'd4,
        IN_RES = 3'd5  // fed back result
    } pe_in_src_t;

    // operand and output sources
    typedef enum logic [3:0] {
        OUT_N   = 4'd0,
        OUT_S   = 4'd1,
        OUT_W   = 4'd2,
        OUT_E   = 4'd3,
        OUT_R0  = 4'd4,
        OUT_R1  = 4'd5,
        OUT_R2  = 4'd6,
        OUT_R3  = 4'd7,
        OUT_RES = 4'd8
    } pe_out_src_t;

    // out_sel field positions, index 0 is the top field
    localparam int DST_A   = 0;
    localparam int DST_B   = 1;
    localparam int DST_N   = 2;
    localparam int DST_S   = 3;
    localparam int DST_W   = 4;
    localparam int DST_E   = 5;
    localparam int DST_LSU = 6;

    typedef struct packed {
        pe_opcode_t        opcode;   // 47:44
        pe_out_src_t [0:6] out_sel;  // 43:16
        pe_in_src_t  [0:3] in_sel;   // 15:4, R0 highest
        logic        [3:0] reg_we;   // bit k writes Rk
    } pe_inst_t;

endpackage

//--- logic/pe_data_pkg.sv
package pe_data_pkg;

    // two 16-bit lanes, no carry between them
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } pe_lanes_t;

    // one data word, scalar or lane view
    typedef union packed {
        logic [31:0] scalar;
        pe_lanes_t   lane;
    } pe_word_t;

endpackage

//--- logic/pe_if.sv
// fields of the instruction at the run pointer
interface pe_cfg_if;
    import pe_config_pkg::*;

    pe_opcode_t        opcode;
    pe_out_src_t [0:6] out_sel;  // A B N S W E LSU
    pe_in_src_t  [0:3] in_sel;   // R0 to R3
    logic        [3:0] reg_we;

    modport source (
        output opcode,
        output out_sel,
        output in_sel,
        output reg_we
    );

    modport sink (
        input opcode,
        input out_sel,
        input in_sel,
        input reg_we
    );
endinterface

// local register file contents
interface pe_reg_if;
    import pe_data_pkg::*;

    pe_word_t r0;
    pe_word_t r1;
    pe_word_t r2;
    pe_word_t r3;

    modport source (output r0, output r1, output r2, output r3);
    modport sink (input r0, input r1, input r2, input r3);
endinterface

//--- logic/pe_config_buffer.sv
`include "pe_macros.svh"

module pe_config_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    init,
    input  logic                    run,
    input  pe_config_pkg::pe_inst_t cfg_word,
    pe_cfg_if.source                cfg
);
    import pe_config_pkg::*;

    localparam int DEPTH = `PE_CFG_DEPTH;
    localparam int PTR_W = `PE_CFG_PTR_W;

    pe_inst_t         slots [DEPTH];
    logic [PTR_W-1:0] load_ptr;
    logic [PTR_W-1:0] run_ptr;
    pe_inst_t         cur;

    // step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (int'(p) == DEPTH - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            load_ptr <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= '0; // NOP, all selects N, no writes
            end
        end else if (init) begin
            slots[load_ptr] <= cfg_word;
            load_ptr        <= ptr_inc(load_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_ptr <= '0;
        end else if (run) begin
            run_ptr <= ptr_inc(run_ptr);
        end
    end

    assign cur = slots[run_ptr]; // combinational read

    assign cfg.opcode  = cur.opcode;
    assign cfg.out_sel = cur.out_sel;
    assign cfg.in_sel  = cur.in_sel;
    assign cfg.reg_we  = cur.reg_we;

    // loading and stepping are separate phases
    assert property (@(posedge clk) disable iff (rst) !(init && run))
        else $error("config buffer: init and run high together");

endmodule

//--- logic/pe_reg_stage.sv
module pe_reg_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  pe_data_pkg::pe_word_t din_n,
    input  pe_data_pkg::pe_word_t din_s,
    input  pe_data_pkg::pe_word_t din_w,
    input  pe_data_pkg::pe_word_t din_e,
    input  pe_data_pkg::pe_word_t din_lsu,
    input  pe_data_pkg::pe_word_t res,
    pe_cfg_if.sink                cfg,
    pe_reg_if.source              regs
);
    import pe_config_pkg::*;
    import pe_data_pkg::*;

    localparam int NREG = 4;

    pe_word_t rf      [NREG];
    pe_word_t rf_next [NREG];

    // 6-way input crossbar, one per register
    always_comb begin
        for (int k = 0; k < NREG; k++) begin
            case (cfg.in_sel[k])
                IN_N:    rf_next[k] = din_n;
                IN_S:    rf_next[k] = din_s;
                IN_W:    rf_next[k] = din_w;
                IN_E:    rf_next[k] = din_e;
                IN_LSU:  rf_next[k] = din_lsu;
                IN_RES:  rf_next[k] = res;
                default: rf_next[k] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NREG; k++) begin
                rf[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NREG; k++) begin
                if (cfg.reg_we[k]) begin
                    rf[k] <= rf_next[k]; // others hold
                end
            end
        end
    end

    assign regs.r0 = rf[0];
    assign regs.r1 = rf[1];
    assign regs.r2 = rf[2];
    assign regs.r3 = rf[3];

    // a register being written must name a real source
    for (genvar k = 0; k < NREG; k++) begin : g_sel_chk
        assert property (@(posedge clk) disable iff (rst)
            cfg.reg_we[k] |-> (cfg.in_sel[k] <= IN_RES))
            else $error("reg stage: R%0d written from undefined source", k);
    end

endmodule

//--- logic/pe_route_stage.sv
module pe_route_stage (
    input  pe_data_pkg::pe_word_t din_n,
    input  pe_data_pkg::pe_word_t din_s,
    input  pe_data_pkg::pe_word_t din_w,
    input  pe_data_pkg::pe_word_t din_e,
    input  pe_data_pkg::pe_word_t res,
    pe_reg_if.sink                regs,
    pe_cfg_if.sink                cfg,
    output pe_data_pkg::pe_word_t op_a,
    output pe_data_pkg::pe_word_t op_b,
    output pe_data_pkg::pe_word_t dout_n,
    output pe_data_pkg::pe_word_t dout_s,
    output pe_data_pkg::pe_word_t dout_w,
    output pe_data_pkg::pe_word_t dout_e,
    output pe_data_pkg::pe_word_t dout_lsu
);
    import pe_config_pkg::*;
    import pe_data_pkg::*;

    localparam int NSRC = 9;
    localparam int NDST = 7;

    pe_word_t src [NSRC];
    pe_word_t dst [NDST];

    always_comb begin
        src[OUT_N]   = din_n;
        src[OUT_S]   = din_s;
        src[OUT_W]   = din_w;
        src[OUT_E]   = din_e;
        src[OUT_R0]  = regs.r0;
        src[OUT_R1]  = regs.r1;
        src[OUT_R2]  = regs.r2;
        src[OUT_R3]  = regs.r3;
        src[OUT_RES] = res;
    end

    // 9x7 crossbar, spare codes give zero
    always_comb begin
        for (int d = 0; d < NDST; d++) begin
            if (cfg.out_sel[d] <= OUT_RES) begin
                dst[d] = src[cfg.out_sel[d]];
            end else begin
                dst[d] = '0;
            end
        end
    end

    assign op_a     = dst[DST_A];
    assign op_b     = dst[DST_B];
    assign dout_n   = dst[DST_N];
    assign dout_s   = dst[DST_S];
    assign dout_w   = dst[DST_W];
    assign dout_e   = dst[DST_E];
    assign dout_lsu = dst[DST_LSU];

    // no clock here, so checked once the inputs settle
    for (genvar d = 0; d < NDST; d++) begin : g_sel_chk
        always_comb begin
            assert final ($isunknown(cfg.out_sel[d]) || cfg.out_sel[d] <= OUT_RES)
                else $error("route stage: out_sel[%0d] above RES", d);
        end
    end

endmodule

//--- logic/pe_alu.sv
module pe_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  pe_data_pkg::pe_word_t op_a,
    input  pe_data_pkg::pe_word_t op_b,
    pe_cfg_if.sink                cfg,
    output pe_data_pkg::pe_word_t res
);
    import pe_config_pkg::*;
    import pe_data_pkg::*;

    pe_word_t   alu_out;
    logic [4:0] shamt;

    assign shamt = op_b.scalar[4:0];

    always_comb begin
        alu_out = '0;
        case (cfg.opcode)
            OP_ADD: begin
                alu_out.scalar = op_a.scalar + op_b.scalar;
            end
            OP_SUB: begin
                alu_out.scalar = op_a.scalar - op_b.scalar;
            end
            OP_AND: begin
                alu_out.scalar = op_a.scalar & op_b.scalar;
            end
            OP_OR: begin
                alu_out.scalar = op_a.scalar | op_b.scalar;
            end
            OP_XOR: begin
                alu_out.scalar = op_a.scalar ^ op_b.scalar;
            end
            OP_SHL: begin
                alu_out.scalar = op_a.scalar << shamt;
            end
            OP_SHR: begin
                alu_out.scalar = op_a.scalar >> shamt;
            end
            OP_MUL: begin
                alu_out.scalar = op_a.scalar * op_b.scalar; // truncated to 32
            end
            OP_ADD2: begin
                // each lane wraps on its own
                alu_out.lane.hi = op_a.lane.hi + op_b.lane.hi;
                alu_out.lane.lo = op_a.lane.lo + op_b.lane.lo;
            end
            OP_SUB2: begin
                alu_out.lane.hi = op_a.lane.hi - op_b.lane.hi;
                alu_out.lane.lo = op_a.lane.lo - op_b.lane.lo;
            end
            OP_PASS_A: begin
                alu_out.scalar = op_a.scalar;
            end
            default: begin
                alu_out = '0; // NOP and spare codes
            end
        endcase
    end

    // result register, loads every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res <= alu_out;
        end
    end

endmodule

//--- logic/pe_top.sv
module pe_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        init,
    input  logic        run,
    input  logic [47:0] cfg_word,
    input  logic [31:0] din_n,
    input  logic [31:0] din_s,
    input  logic [31:0] din_w,
    input  logic [31:0] din_e,
    input  logic [31:0] din_lsu,
    output logic [31:0] dout_n,
    output logic [31:0] dout_s,
    output logic [31:0] dout_w,
    output logic [31:0] dout_e,
    output logic [31:0] dout_lsu
);
    import pe_data_pkg::*;

    pe_word_t res;
    pe_word_t op_a;
    pe_word_t op_b;

    pe_cfg_if cfg_bus ();
    pe_reg_if reg_bus ();

    pe_config_buffer cfg_buf_inst (
        .clk      (clk),
        .rst      (rst),
        .init     (init),
        .run      (run),
        .cfg_word (cfg_word),
        .cfg      (cfg_bus.source)
    );

    pe_reg_stage reg_stage_inst (
        .clk     (clk),
        .rst     (rst),
        .din_n   (din_n),
        .din_s   (din_s),
        .din_w   (din_w),
        .din_e   (din_e),
        .din_lsu (din_lsu),
        .res     (res),
        .cfg     (cfg_bus.sink),
        .regs    (reg_bus.source)
    );

    pe_route_stage route_stage_inst (
        .din_n    (din_n),
        .din_s    (din_s),
        .din_w    (din_w),
        .din_e    (din_e),
        .res      (res),
        .regs     (reg_bus.sink),
        .cfg      (cfg_bus.sink),
        .op_a     (op_a),
        .op_b     (op_b),
        .dout_n   (dout_n),
        .dout_s   (dout_s),
        .dout_w   (dout_w),
        .dout_e   (dout_e),
        .dout_lsu (dout_lsu)
    );

    pe_alu alu_inst (
        .clk  (clk),
        .rst  (rst),
        .op_a (op_a),
        .op_b (op_b),
        .cfg  (cfg_bus.sink),
        .res  (res)
    );

endmodule

//--- testbench/pe_tb.sv
`include "pe_macros.svh"

module pe_tb;
    import pe_config_pkg::*;

    localparam int DEPTH = `PE_CFG_DEPTH;

    logic        clk;
    logic        rst;
    logic        init;
    logic        run;
    logic [47:0] cfg_word;
    logic [31:0] din_n;
    logic [31:0] din_s;
    logic [31:0] din_w;
    logic [31:0] din_e;
    logic [31:0] din_lsu;
    logic [31:0] dout_n;
    logic [31:0] dout_s;
    logic [31:0] dout_w;
    logic [31:0] dout_e;
    logic [31:0] dout_lsu;

    logic [31:0] rng;
    logic [47:0] prog [DEPTH]; // program to load

    // reference model state
    logic [47:0]      m_prog [DEPTH];
    int               m_load;
    int               m_run;
    logic [31:0]      m_r [4];
    logic [31:0]      m_res;
    logic [47:0]      cur_inst;
    logic [6:0][31:0] exp_out; // A B N S W E LSU
    logic [3:0][31:0] reg_in;

    pe_top pe_top_inst (
        .clk      (clk),
        .rst      (rst),
        .init     (init),
        .run      (run),
        .cfg_word (cfg_word),
        .din_n    (din_n),
        .din_s    (din_s),
        .din_w    (din_w),
        .din_e    (din_e),
        .din_lsu  (din_lsu),
        .dout_n   (dout_n),
        .dout_s   (dout_s),
        .dout_w   (dout_w),
        .dout_e   (dout_e),
        .dout_lsu (dout_lsu)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] expected_alu(input logic [3:0] op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [31:0] r;
        r = '0;
        case (op)
            OP_ADD:    r = a + b;
            OP_SUB:    r = a - b;
            OP_AND:    r = a & b;
            OP_OR:     r = a | b;
            OP_XOR:    r = a ^ b;
            OP_SHL:    r = a << b[4:0];
            OP_SHR:    r = a >> b[4:0];
            OP_MUL:    r = a * b;
            OP_ADD2: begin
                r[31:16] = a[31:16] + b[31:16]; // lanes wrap apart
                r[15:0]  = a[15:0] + b[15:0];
            end
            OP_SUB2: begin
                r[31:16] = a[31:16] - b[31:16];
                r[15:0]  = a[15:0] - b[15:0];
            end
            OP_PASS_A: r = a;
            default:   r = '0;
        endcase
        return r;
    endfunction

    // current slot decoded by field position
    always_comb begin
        logic [3:0] sel;
        cur_inst = m_prog[m_run];
        for (int d = 0; d < 7; d++) begin
            sel = cur_inst[43 - 4 * d -: 4];
            case (sel)
                OUT_N:   exp_out[d] = din_n;
                OUT_S:   exp_out[d] = din_s;
                OUT_W:   exp_out[d] = din_w;
                OUT_E:   exp_out[d] = din_e;
                OUT_R0:  exp_out[d] = m_r[0];
                OUT_R1:  exp_out[d] = m_r[1];
                OUT_R2:  exp_out[d] = m_r[2];
                OUT_R3:  exp_out[d] = m_r[3];
                OUT_RES: exp_out[d] = m_res;
                default: exp_out[d] = '0;
            endcase
        end
        for (int k = 0; k < 4; k++) begin
            case (cur_inst[15 - 3 * k -: 3])
                IN_N:    reg_in[k] = din_n;
                IN_S:    reg_in[k] = din_s;
                IN_W:    reg_in[k] = din_w;
                IN_E:    reg_in[k] = din_e;
                IN_LSU:  reg_in[k] = din_lsu;
                IN_RES:  reg_in[k] = m_res;
                default: reg_in[k] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_load <= 0;
            m_run  <= 0;
            m_res  <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                m_prog[i] <= '0;
            end
            for (int k = 0; k < 4; k++) begin
                m_r[k] <= '0;
            end
        end else begin
            if (init) begin
                m_prog[m_load] <= cfg_word;
                m_load         <= (m_load + 1) % DEPTH;
            end
            if (run) begin
                m_run <= (m_run + 1) % DEPTH;
            end
            for (int k = 0; k < 4; k++) begin
                if (cur_inst[k]) begin
                    m_r[k] <= reg_in[k];
                end
            end
            m_res <= expected_alu(cur_inst[47:44], exp_out[0], exp_out[1]);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail %0t: %s is %h, expected %h", $time, name, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "output mismatch");
    endtask

    assert property (@(posedge clk) disable iff (rst) dout_n == exp_out[2])
        else report_mismatch("dout_n", $sampled(dout_n), $sampled(exp_out[2]));
    assert property (@(posedge clk) disable iff (rst) dout_s == exp_out[3])
        else report_mismatch("dout_s", $sampled(dout_s), $sampled(exp_out[3]));
    assert property (@(posedge clk) disable iff (rst) dout_w == exp_out[4])
        else report_mismatch("dout_w", $sampled(dout_w), $sampled(exp_out[4]));
    assert property (@(posedge clk) disable iff (rst) dout_e == exp_out[5])
        else report_mismatch("dout_e", $sampled(dout_e), $sampled(exp_out[5]));
    assert property (@(posedge clk) disable iff (rst) dout_lsu == exp_out[6])
        else report_mismatch("dout_lsu", $sampled(dout_lsu), $sampled(exp_out[6]));

    task automatic drive_random_data();
        rng = xorshift32(rng);
        din_n <= rng;
        rng = xorshift32(rng);
        din_s <= rng;
        rng = xorshift32(rng);
        din_w <= rng;
        rng = xorshift32(rng);
        din_e <= rng;
        rng = xorshift32(rng);
        din_lsu <= rng;
    endtask

    // one opcode per slot in turn, random routing, lsu always shows res
    task automatic build_program();
        logic [47:0] w;
        for (int i = 0; i < DEPTH; i++) begin
            w = '0;
            w[47:44] = 4'(i % 12);
            for (int d = 0; d < 6; d++) begin
                rng = xorshift32(rng);
                w[43 - 4 * d -: 4] = 4'(rng % 9);
            end
            w[19:16] = OUT_RES;
            for (int k = 0; k < 4; k++) begin
                rng = xorshift32(rng);
                w[15 - 3 * k -: 3] = 3'(rng % 6);
            end
            rng = xorshift32(rng);
            w[3:0] = rng[3:0];
            prog[i] = w;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < DEPTH; i++) begin
            @(posedge clk);
            init     <= 1'b1;
            cfg_word <= prog[i];
            drive_random_data();
        end
        @(posedge clk);
        init     <= 1'b0;
        cfg_word <= '0;
        drive_random_data();
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            drive_random_data();
        end
    endtask

    // pending step counted, since run high now moves the pointer next edge
    task automatic run_to_slot(input int target, input int limit);
        int n;
        int pending;
        n = 0;
        @(negedge clk);
        pending = run ? (m_run + 1) % DEPTH : m_run;
        while (pending != target) begin
            if (n == limit) begin
                $display("timeout: run pointer did not reach slot %0d in %0d cycles",
                         target, limit);
                $display("STATUS: FAIL");
                $fatal(1, "timeout");
            end
            n++;
            @(posedge clk);
            run <= 1'b1;
            drive_random_data();
            @(negedge clk);
            pending = run ? (m_run + 1) % DEPTH : m_run;
        end
        @(posedge clk);
        run <= 1'b0;
        drive_random_data();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst  <= 1'b1;
        init <= 1'b0;
        run  <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    initial begin
        rst      = 1'b1;
        init     = 1'b0;
        run      = 1'b0;
        cfg_word = '0;
        din_n    = '0;
        din_s    = '0;
        din_w    = '0;
        din_e    = '0;
        din_lsu  = '0;
        rng      = 32'h4cd7;
        build_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(8);      // empty program, all outputs follow din_n
        load_program();
        idle_cycles(4);
        for (int lap = 0; lap < 3; lap++) begin
            run_to_slot(DEPTH / 2, 2 * DEPTH);
            run_to_slot(0, 2 * DEPTH);  // wraps
        end
        apply_reset();
        idle_cycles(8);      // program cleared again
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
logic/pe_config_pkg.sv
logic/pe_data_pkg.sv
logic/pe_if.sv
logic/pe_config_buffer.sv
logic/pe_reg_stage.sv
logic/pe_route_stage.sv
logic/pe_alu.sv
logic/pe_top.sv
testbench/pe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the PE testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module pe_tb -o pe_sim

out=$(./obj_dir/pe_sim) || true
echo "$out"

if grep -q "^STATUS: PASS$" <<< "$out"; then
    exit 0
fi
exit 1
